// File: hw/alu_ops_pkg.sv
package alu_ops_pkg;

    localparam int WORD_W  = 32;
    localparam int SHAMT_W = 5;

    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [2*WORD_W-1:0] dword_t;    // Full product, or the HI/LO pair
    typedef logic [4:0]          reg_addr_t;

    typedef enum logic [4:0] {
        op_or    = 5'd0,
        op_and   = 5'd1,
        op_nor   = 5'd2,
        op_xor   = 5'd3,
        op_sll   = 5'd4,
        op_srl   = 5'd5,
        op_sra   = 5'd6,
        op_add   = 5'd7,     // Traps on signed overflow by cancelling the write
        op_addu  = 5'd8,
        op_sub   = 5'd9,     // Same overflow rule as op_add
        op_subu  = 5'd10,
        op_slt   = 5'd11,
        op_sltu  = 5'd12,
        op_clz   = 5'd13,
        op_clo   = 5'd14,
        op_movz  = 5'd15,
        op_movn  = 5'd16,
        op_mfhi  = 5'd17,
        op_mflo  = 5'd18,
        op_mthi  = 5'd19,
        op_mtlo  = 5'd20,
        op_mul   = 5'd21,    // Low word of the signed product goes to a register
        op_mult  = 5'd22,
        op_multu = 5'd23
    } alu_op_e;

    // Which unit result reaches the register write port
    typedef enum logic [1:0] {
        logic_shift,
        arith,
        move,
        mult
    } unit_sel_e;

endpackage

// File: hw/pipe_pkg.sv
package pipe_pkg;

    // One operation as it enters the pipeline and waits in the issue stage
    typedef struct packed {
        alu_ops_pkg::alu_op_e   op;
        alu_ops_pkg::word_t     operand_a;    // rs, also the shift amount source
        alu_ops_pkg::word_t     operand_b;    // rt, also the shifted value
        alu_ops_pkg::reg_addr_t dest;
        logic                   write_req;    // Decoder asks for a register write
    } alu_req_t;

    // Register file write-back packet leaving the pipeline
    typedef struct packed {
        alu_ops_pkg::reg_addr_t dest;
        logic                   write_enable;
        alu_ops_pkg::word_t     data;
    } gpr_write_t;

endpackage

// File: hw/issue_stage.sv
`timescale 1ns/1ps

module issue_stage (
    input  logic               clk,
    input  logic               reset,

    input  logic               in_valid,
    output logic               in_ready,
    input  pipe_pkg::alu_req_t in_req,

    output logic               iss_valid,
    input  logic               iss_ready,
    output pipe_pkg::alu_req_t iss_req
);

    logic accept;

    // Room when the slot is empty or its item moves on this cycle
    assign in_ready = !iss_valid || iss_ready;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            iss_valid <= 1'b0;
        end else if (in_ready) begin
            iss_valid <= in_valid;      // Refill or empty once the old item has gone
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            iss_req <= in_req;          // Held stable while exec_stage stalls
        end
    end

endmodule

// File: hw/arith_unit.sv
`timescale 1ns/1ps

module arith_unit (
    input  alu_ops_pkg::alu_op_e op,
    input  alu_ops_pkg::word_t   operand_a,
    input  alu_ops_pkg::word_t   operand_b,
    output alu_ops_pkg::word_t   result,
    output logic                 overflow
);

    logic               subtract;
    alu_ops_pkg::word_t addend;
    alu_ops_pkg::word_t sum;
    logic               slt_bit;
    logic               sltu_bit;
    alu_ops_pkg::word_t count_src;
    logic [5:0]         lead_count;

    assign subtract = (op == alu_ops_pkg::op_sub) || (op == alu_ops_pkg::op_subu)
                   || (op == alu_ops_pkg::op_slt);

    // Subtraction adds the inverted operand with a carry in of one
    assign addend = subtract ? ~operand_b : operand_b;
    assign sum    = operand_a + addend + alu_ops_pkg::word_t'(subtract);

    // Signed overflow when both adder inputs agree in sign and the sum does not
    assign overflow = (operand_a[alu_ops_pkg::WORD_W-1] == addend[alu_ops_pkg::WORD_W-1])
                   && (sum[alu_ops_pkg::WORD_W-1] != operand_a[alu_ops_pkg::WORD_W-1]);

    assign slt_bit  = sum[alu_ops_pkg::WORD_W-1] ^ overflow;   // True sign of a - b
    assign sltu_bit = operand_a < operand_b;

    // CLO counts leading zeros of the inverted operand
    assign count_src = (op == alu_ops_pkg::op_clo) ? ~operand_a : operand_a;

    always_comb begin
        logic found;
        found      = 1'b0;
        lead_count = 6'(alu_ops_pkg::WORD_W);   // All zeros gives the full width
        for (int i = alu_ops_pkg::WORD_W - 1; i >= 0; i--) begin
            if (!found && count_src[i]) begin
                lead_count = 6'(alu_ops_pkg::WORD_W - 1 - i);
                found      = 1'b1;
            end
        end
    end

    always_comb begin
        case (op)
            alu_ops_pkg::op_add,
            alu_ops_pkg::op_addu,
            alu_ops_pkg::op_sub,
            alu_ops_pkg::op_subu: begin
                result = sum;
            end
            alu_ops_pkg::op_slt: begin
                result = alu_ops_pkg::word_t'(slt_bit);
            end
            alu_ops_pkg::op_sltu: begin
                result = alu_ops_pkg::word_t'(sltu_bit);
            end
            alu_ops_pkg::op_clz,
            alu_ops_pkg::op_clo: begin
                result = alu_ops_pkg::word_t'(lead_count);
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// File: hw/logic_shift_unit.sv
`timescale 1ns/1ps

module logic_shift_unit (
    input  alu_ops_pkg::alu_op_e op,
    input  alu_ops_pkg::word_t   operand_a,
    input  alu_ops_pkg::word_t   operand_b,
    output alu_ops_pkg::word_t   result
);

    logic [alu_ops_pkg::SHAMT_W-1:0] shamt;

    assign shamt = operand_a[alu_ops_pkg::SHAMT_W-1:0];    // Only the low five bits count

    always_comb begin
        case (op)
            alu_ops_pkg::op_or: begin
                result = operand_a | operand_b;
            end
            alu_ops_pkg::op_and: begin
                result = operand_a & operand_b;
            end
            alu_ops_pkg::op_nor: begin
                result = ~(operand_a | operand_b);
            end
            alu_ops_pkg::op_xor: begin
                result = operand_a ^ operand_b;
            end
            alu_ops_pkg::op_sll: begin
                result = operand_b << shamt;
            end
            alu_ops_pkg::op_srl: begin
                result = operand_b >> shamt;
            end
            alu_ops_pkg::op_sra: begin
                // Fill comes from the sign of the shifted value
                result = alu_ops_pkg::word_t'($signed(operand_b) >>> shamt);
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// File: hw/mult_unit.sv
`timescale 1ns/1ps

module mult_unit (
    input  alu_ops_pkg::alu_op_e op,
    input  alu_ops_pkg::word_t   operand_a,
    input  alu_ops_pkg::word_t   operand_b,
    output alu_ops_pkg::dword_t  product
);

    localparam int MSB = alu_ops_pkg::WORD_W - 1;

    logic                signed_op;
    logic                negate;
    alu_ops_pkg::word_t  mag_a;
    alu_ops_pkg::word_t  mag_b;
    alu_ops_pkg::dword_t raw_product;

    assign signed_op = (op == alu_ops_pkg::op_mul) || (op == alu_ops_pkg::op_mult);

    // Magnitudes are taken only for signed opcodes, MULTU uses the raw words
    assign mag_a = (signed_op && operand_a[MSB]) ? (~operand_a + 1'b1) : operand_a;
    assign mag_b = (signed_op && operand_b[MSB]) ? (~operand_b + 1'b1) : operand_b;

    assign raw_product = alu_ops_pkg::dword_t'(mag_a) * alu_ops_pkg::dword_t'(mag_b);

    assign negate  = signed_op && (operand_a[MSB] ^ operand_b[MSB]);   // Signs differ
    assign product = negate ? (~raw_product + 1'b1) : raw_product;

endmodule

// File: hw/hilo_regs.sv
`timescale 1ns/1ps

module hilo_regs (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 write_strobe,
    input  alu_ops_pkg::alu_op_e op,
    input  alu_ops_pkg::word_t   operand_a,
    input  alu_ops_pkg::dword_t  product,
    output alu_ops_pkg::word_t   hi,
    output alu_ops_pkg::word_t   lo
);

    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else if (write_strobe) begin
            case (op)
                alu_ops_pkg::op_mult,
                alu_ops_pkg::op_multu: begin
                    {hi, lo} <= product;    // Upper half of the product lands in HI
                end
                alu_ops_pkg::op_mthi: begin
                    hi <= operand_a;        // LO keeps its value
                end
                alu_ops_pkg::op_mtlo: begin
                    lo <= operand_a;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

// File: hw/exec_stage.sv
`timescale 1ns/1ps

module exec_stage (
    input  logic                 clk,
    input  logic                 reset,

    input  logic                 iss_valid,
    output logic                 iss_ready,
    input  pipe_pkg::alu_req_t   iss_req,

    output logic                 out_valid,
    input  logic                 out_ready,
    output pipe_pkg::gpr_write_t out_result
);

    alu_ops_pkg::unit_sel_e unit_sel;
    alu_ops_pkg::word_t     arith_result;
    alu_ops_pkg::word_t     ls_result;
    alu_ops_pkg::word_t     move_result;
    alu_ops_pkg::dword_t    product;
    alu_ops_pkg::word_t     hi;
    alu_ops_pkg::word_t     lo;
    logic                   overflow;
    logic                   hilo_write_op;
    logic                   iss_xfer;
    pipe_pkg::gpr_write_t   next_result;

    arith_unit arith_unit_i (
        .op        (iss_req.op),
        .operand_a (iss_req.operand_a),
        .operand_b (iss_req.operand_b),
        .result    (arith_result),
        .overflow  (overflow)
    );

    logic_shift_unit logic_shift_unit_i (
        .op        (iss_req.op),
        .operand_a (iss_req.operand_a),
        .operand_b (iss_req.operand_b),
        .result    (ls_result)
    );

    mult_unit mult_unit_i (
        .op        (iss_req.op),
        .operand_a (iss_req.operand_a),
        .operand_b (iss_req.operand_b),
        .product   (product)
    );

    // HI/LO update on the same edge the operation leaves the issue stage
    hilo_regs hilo_regs_i (
        .clk          (clk),
        .reset        (reset),
        .write_strobe (iss_xfer && hilo_write_op),
        .op           (iss_req.op),
        .operand_a    (iss_req.operand_a),
        .product      (product),
        .hi           (hi),
        .lo           (lo)
    );

    assign iss_ready = !out_valid || out_ready;    // Output slot free or draining
    assign iss_xfer  = iss_valid && iss_ready;

    assign hilo_write_op = iss_req.op inside {alu_ops_pkg::op_mult, alu_ops_pkg::op_multu,
                                              alu_ops_pkg::op_mthi, alu_ops_pkg::op_mtlo};

    always_comb begin
        case (iss_req.op)
            alu_ops_pkg::op_or, alu_ops_pkg::op_and, alu_ops_pkg::op_nor, alu_ops_pkg::op_xor,
            alu_ops_pkg::op_sll, alu_ops_pkg::op_srl, alu_ops_pkg::op_sra: begin
                unit_sel = alu_ops_pkg::logic_shift;
            end
            alu_ops_pkg::op_movz, alu_ops_pkg::op_movn, alu_ops_pkg::op_mfhi,
            alu_ops_pkg::op_mflo, alu_ops_pkg::op_mthi, alu_ops_pkg::op_mtlo: begin
                unit_sel = alu_ops_pkg::move;
            end
            alu_ops_pkg::op_mul, alu_ops_pkg::op_mult, alu_ops_pkg::op_multu: begin
                unit_sel = alu_ops_pkg::mult;
            end
            default: begin
                unit_sel = alu_ops_pkg::arith;
            end
        endcase
    end

    always_comb begin
        case (iss_req.op)
            alu_ops_pkg::op_mfhi: move_result = hi;
            alu_ops_pkg::op_mflo: move_result = lo;
            default:              move_result = iss_req.operand_a;   // MOVZ and MOVN pass rs
        endcase
    end

    always_comb begin
        next_result.dest = iss_req.dest;
        case (unit_sel)
            alu_ops_pkg::logic_shift: next_result.data = ls_result;
            alu_ops_pkg::move:        next_result.data = move_result;
            alu_ops_pkg::mult:        next_result.data = product[alu_ops_pkg::WORD_W-1:0];
            default:                  next_result.data = arith_result;
        endcase
        case (iss_req.op)
            alu_ops_pkg::op_add, alu_ops_pkg::op_sub: begin
                next_result.write_enable = iss_req.write_req && !overflow;
            end
            alu_ops_pkg::op_movz: begin
                next_result.write_enable = iss_req.write_req && (iss_req.operand_b == '0);
            end
            alu_ops_pkg::op_movn: begin
                next_result.write_enable = iss_req.write_req && (iss_req.operand_b != '0);
            end
            alu_ops_pkg::op_mult, alu_ops_pkg::op_multu,
            alu_ops_pkg::op_mthi, alu_ops_pkg::op_mtlo: begin
                next_result.write_enable = 1'b0;   // These only touch HI/LO
            end
            default: begin
                next_result.write_enable = iss_req.write_req;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (iss_ready) begin
            out_valid <= iss_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (iss_xfer) begin
            out_result <= next_result;
        end
    end

endmodule

// File: hw/alu_pipe.sv
`timescale 1ns/1ps

// Two register stages, so a result leaves two edges after its operation is taken in
module alu_pipe (
    input  logic                 clk,
    input  logic                 reset,

    input  logic                 in_valid,
    output logic                 in_ready,
    input  pipe_pkg::alu_req_t   in_req,

    output logic                 out_valid,
    input  logic                 out_ready,
    output pipe_pkg::gpr_write_t out_result
);

    logic               iss_valid;
    logic               iss_ready;
    pipe_pkg::alu_req_t iss_req;

    issue_stage issue_stage_i (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_req    (in_req),
        .iss_valid (iss_valid),
        .iss_ready (iss_ready),
        .iss_req   (iss_req)
    );

    exec_stage exec_stage_i (
        .clk        (clk),
        .reset      (reset),
        .iss_valid  (iss_valid),
        .iss_ready  (iss_ready),    // Back-pressure from the output register
        .iss_req    (iss_req),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_result (out_result)
    );

endmodule

// File: dv/alu_pipe_sva.sv
`timescale 1ns/1ps

module alu_pipe_sva (
    input logic                 clk,
    input logic                 reset,
    input logic                 in_ready,
    input logic                 out_valid,
    input logic                 out_ready,
    input pipe_pkg::gpr_write_t out_result
);

    // Output register is empty right after a reset edge
    out_empty_after_reset: assert property (@(posedge clk) reset |=> !out_valid)
        else $error("out_valid high in the cycle after reset");

    stalled_result_stable: assert property (@(posedge clk) disable iff (reset)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_result)))
        else $error("out_result changed while the output was stalled");

    // Two cycles of downstream ready always leave room at the input
    input_ready_when_drained: assert property (@(posedge clk) disable iff (reset)
        ($past(out_ready) && out_ready) |-> in_ready)
        else $error("in_ready low although out_ready was high for two cycles");

endmodule

bind alu_pipe alu_pipe_sva alu_pipe_sva_i (
    .clk        (clk),
    .reset      (reset),
    .in_ready   (in_ready),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_result (out_result)
);

// File: dv/alu_pipe_tb.sv
`timescale 1ns/1ps

module alu_pipe_tb;

    logic                 clk;
    logic                 reset;
    logic                 in_valid;
    logic                 in_ready;
    pipe_pkg::alu_req_t   in_req;
    logic                 out_valid;
    logic                 out_ready;
    pipe_pkg::gpr_write_t out_result;

    integer               seed;
    int                   errors;
    int                   checks;
    int                   timeouts;
    int                   cycle;
    logic                 took_input;       // Input transfer seen on the last rising edge
    logic                 strict_timing;
    alu_ops_pkg::word_t   model_hi;
    alu_ops_pkg::word_t   model_lo;
    pipe_pkg::gpr_write_t exp_q[$];
    int                   accept_q[$];
    logic                 strict_q[$];

    alu_pipe alu_pipe_i (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_req     (in_req),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_result (out_result)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic alu_ops_pkg::word_t pick_operand();
        logic [31:0] kind;
        logic [31:0] value;
        kind  = $random(seed);
        value = $random(seed);
        case (kind[2:0])
            3'd0: return '0;
            3'd1: return '1;
            3'd2: return 32'h8000_0000;
            3'd3: return 32'h7fff_ffff;
            3'd4: return value >> kind[7:3];       // Spreads the leading zero count
            3'd5: return ~(value >> kind[7:3]);    // Spreads the leading one count
            default: return value;
        endcase
    endfunction

    function automatic pipe_pkg::alu_req_t make_request();
        pipe_pkg::alu_req_t req;
        logic [31:0]        r;
        r             = $random(seed);
        req.op        = alu_ops_pkg::alu_op_e'(5'(r[30:0] % 31'd24));
        req.dest      = r[12:8];
        req.write_req = (r[15:13] != 3'd0);
        req.operand_a = pick_operand();
        req.operand_b = pick_operand();
        return req;
    endfunction

    // Reference model in program order, with its own HI and LO
    task automatic model_op(input pipe_pkg::alu_req_t req, output pipe_pkg::gpr_write_t exp);
        alu_ops_pkg::word_t a;
        alu_ops_pkg::word_t b;
        longint             wa;
        longint             wb;
        logic [63:0]        uprod;
        logic               count_bit;
        a                = req.operand_a;
        b                = req.operand_b;
        wa               = $signed(a);
        wb               = $signed(b);
        count_bit        = (req.op == alu_ops_pkg::op_clo);
        exp.dest         = req.dest;
        exp.write_enable = req.write_req;
        exp.data         = '0;
        case (req.op)
            alu_ops_pkg::op_or:   exp.data = a | b;
            alu_ops_pkg::op_and:  exp.data = a & b;
            alu_ops_pkg::op_nor:  exp.data = ~(a | b);
            alu_ops_pkg::op_xor:  exp.data = a ^ b;
            alu_ops_pkg::op_sll:  exp.data = b << a[4:0];
            alu_ops_pkg::op_srl:  exp.data = b >> a[4:0];
            alu_ops_pkg::op_sra: begin
                exp.data = b;
                repeat (a[4:0])
                    exp.data = {exp.data[31], exp.data[31:1]};   // One place at a time
            end
            alu_ops_pkg::op_add, alu_ops_pkg::op_sub: begin
                wa = (req.op == alu_ops_pkg::op_add) ? wa + wb : wa - wb;
                exp.data = wa[31:0];
                exp.write_enable = req.write_req && (wa[32] == wa[31]);   // Fits in 32 bits
            end
            alu_ops_pkg::op_addu: exp.data = a + b;
            alu_ops_pkg::op_subu: exp.data = a - b;
            alu_ops_pkg::op_slt:  exp.data = (wa < wb) ? 32'd1 : 32'd0;
            alu_ops_pkg::op_sltu: exp.data = (a < b) ? 32'd1 : 32'd0;
            alu_ops_pkg::op_clz, alu_ops_pkg::op_clo: begin
                for (int i = 31; i >= 0; i--) begin
                    if (a[i] != count_bit) begin
                        break;
                    end
                    exp.data = exp.data + 1;
                end
            end
            alu_ops_pkg::op_movz: begin
                exp.data = a;
                exp.write_enable = req.write_req && (b == 0);
            end
            alu_ops_pkg::op_movn: begin
                exp.data = a;
                exp.write_enable = req.write_req && (b != 0);
            end
            alu_ops_pkg::op_mfhi: exp.data = model_hi;
            alu_ops_pkg::op_mflo: exp.data = model_lo;
            alu_ops_pkg::op_mul:  exp.data = 32'(wa * wb);
            default: begin
                exp.write_enable = 1'b0;                // HI/LO writers never touch a register
                if (req.op == alu_ops_pkg::op_mthi) begin
                    model_hi = a;
                end else if (req.op == alu_ops_pkg::op_mtlo) begin
                    model_lo = a;
                end else if (req.op == alu_ops_pkg::op_mult) begin
                    {model_hi, model_lo} = wa * wb;
                end else begin
                    uprod = {32'd0, a} * {32'd0, b};
                    {model_hi, model_lo} = uprod;
                end
            end
        endcase
    endtask

    task automatic check_result(input pipe_pkg::gpr_write_t got,
                                input pipe_pkg::gpr_write_t exp);
        checks++;
        // Data carries no meaning when the packet writes nothing
        if (got.dest !== exp.dest || got.write_enable !== exp.write_enable
            || (exp.write_enable && got.data !== exp.data)) begin
            errors++;
            $display("ERROR at %0t: got dest %0d we %0b data %h, expected dest %0d we %0b data %h",
                     $time, got.dest, got.write_enable, got.data,
                     exp.dest, exp.write_enable, exp.data);
        end
    endtask

    task automatic check_latency(input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("ERROR at %0t: result took %0d cycles, expected %0d", $time, got, exp);
        end
    endtask

    always @(posedge clk) begin
        pipe_pkg::gpr_write_t exp;
        int                   accepted_at;
        logic                 strict;
        took_input = in_valid && in_ready;
        if (!reset && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("An output transfer at %0t had no operation outstanding", $time);
            end else begin
                exp         = exp_q.pop_front();
                accepted_at = accept_q.pop_front();
                strict      = strict_q.pop_front();
                check_result(out_result, exp);
                if (strict) begin
                    check_latency(cycle - accepted_at, 2);
                end
            end
        end
        if (!reset && took_input) begin
            model_op(in_req, exp);
            exp_q.push_back(exp);
            accept_q.push_back(cycle);
            strict_q.push_back(strict_timing);
        end
        cycle++;
    end

    // Offers count operations and keeps going until every result has come out
    task automatic send_ops(input int count, input logic random_flow);
        int left;
        int cycles;
        left   = count;
        cycles = 0;
        while ((left > 0 || in_valid || exp_q.size() != 0) && timeouts == 0) begin
            @(negedge clk);
            cycles++;
            if (!in_valid || took_input) begin
                if (left > 0 && (!random_flow || ($random(seed) & 3) != 0)) begin
                    in_req   = make_request();
                    in_valid = 1'b1;
                    left--;
                end else begin
                    in_valid = 1'b0;
                end
            end
            out_ready = random_flow ? 1'($random(seed)) : 1'b1;
            if (cycles > 10 * count + 100) begin
                timeouts++;
                $display("Timed out with %0d operations unsent and %0d results outstanding",
                         left, exp_q.size());
            end
        end
        in_valid = 1'b0;
    endtask

    task automatic finish_run();
        $display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    initial begin
        seed          = 32'h9a71_ca6f;
        errors        = 0;
        checks        = 0;
        timeouts      = 0;
        cycle         = 0;
        took_input    = 1'b0;
        strict_timing = 1'b0;
        model_hi      = '0;
        model_lo      = '0;
        reset         = 1'b1;
        in_valid      = 1'b0;
        in_req        = '0;
        out_ready     = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        send_ops(800, 1'b1);                // Random valid and ready on both sides
        if (timeouts == 0) begin
            strict_timing = 1'b1;           // Full rate from here on
            send_ops(300, 1'b0);
        end
        finish_run();
    end

endmodule

// File: alu_pipe.f
hw/alu_ops_pkg.sv
hw/pipe_pkg.sv
hw/issue_stage.sv
hw/arith_unit.sv
hw/logic_shift_unit.sv
hw/mult_unit.sv
hw/hilo_regs.sv
hw/exec_stage.sv
hw/alu_pipe.sv
dv/alu_pipe_sva.sv
dv/alu_pipe_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds and runs alu_pipe_tb with Verilator, then searches the log for the fail message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module alu_pipe_tb \
    -f alu_pipe.f -o alu_pipe_sim > build.log 2>&1 \
    && ./obj_dir/alu_pipe_sim > sim.log 2>&1 \
    || { echo "Build or simulation aborted, see build.log and sim.log"; exit 1; }

grep -q "Finished with errors" sim.log \
    && { echo "Simulation failed, see sim.log"; exit 1; } \
    || echo "Simulation passed"
